//--- source/rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// datapath word, also the width of pc and every immediate
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NREGS 32

// bits needed to name one register
`define RV_REGW 5

`endif

//--- source/rv32i_pkg.sv
`default_nettype none

`include "rv32i_settings.svh"

package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,                // load upper immediate
        op_auipc = 7'b0010111,                // add upper immediate to pc
        op_jal   = 7'b1101111,                // jump and link
        op_jalr  = 7'b1100111,                // jump and link register
        op_br    = 7'b1100011,                // conditional branch
        op_load  = 7'b0000011,                // lb lh lw lbu lhu
        op_store = 7'b0100011,                // sb sh sw
        op_imm   = 7'b0010011,                // alu with i immediate
        op_reg   = 7'b0110011,                // alu register-register
        op_csr   = 7'b1110011                 // system, not decoded here
    } rv32i_opcode;

    // low codes line up with funct3 of the alu ops
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alu1_sel_t;

    typedef enum logic [1:0] {
        alu2_rs2   = 2'b00,
        alu2_i_imm = 2'b01,
        alu2_s_imm = 2'b10,
        alu2_u_imm = 2'b11
    } alu2_sel_t;

    typedef struct packed {
        rv32i_opcode opcode;                  // copy of the decoded opcode
        alu_ops      alu_op;
        logic [2:0]  cmp_op;                  // branch compare, funct3
        alu1_sel_t   alu1_sel;
        alu2_sel_t   alu2_sel;
        logic        load_regfile;            // rd gets written at wb
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        illegal;                 // opcode not recognised
    } rv32i_control_word;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetch_bundle;

    typedef struct packed {
        logic                load;            // one-cycle write strobe
        logic [`RV_REGW-1:0] rd;
        logic [`RV_XLEN-1:0] data;
    } wb_bundle;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1;             // register data, not index
        logic [`RV_XLEN-1:0] rs2;
        logic [`RV_REGW-1:0] rd;
        logic [2:0]          funct3;
        logic [`RV_XLEN-1:0] i_imm;
        logic [`RV_XLEN-1:0] s_imm;
        logic [`RV_XLEN-1:0] b_imm;
        logic [`RV_XLEN-1:0] u_imm;
        logic [`RV_XLEN-1:0] j_imm;
        rv32i_control_word   ctrl;
    } stage_regs;

endpackage : rv32i_pkg

`default_nettype wire

//--- source/pipe_reg.sv
`default_nettype none

// generic pipeline register, one instance per stage boundary
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,                    // low holds the current item
    input  payload_t in,
    output payload_t out
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;                        // valid and ctrl come up zero
        end else if (load) begin
            out <= in;
        end
    end

endmodule : pipe_reg

`default_nettype wire

//--- source/instr_fields.sv
`default_nettype none

`include "rv32i_settings.svh"

module instr_fields (
    input  logic [`RV_XLEN-1:0]  instr,
    output rv32i_pkg::rv32i_opcode opcode,
    output logic [2:0]           funct3,
    output logic [6:0]           funct7,
    output logic [`RV_REGW-1:0]  rs1_idx,
    output logic [`RV_REGW-1:0]  rs2_idx,
    output logic [`RV_REGW-1:0]  rd_idx,
    output logic [`RV_XLEN-1:0]  i_imm,
    output logic [`RV_XLEN-1:0]  s_imm,
    output logic [`RV_XLEN-1:0]  b_imm,
    output logic [`RV_XLEN-1:0]  u_imm,
    output logic [`RV_XLEN-1:0]  j_imm
);

    assign opcode  = rv32i_pkg::rv32i_opcode'(instr[6:0]);   // unknown codes pass through
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    // instr[31] is the sign bit of every signed format
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};       // split across rd slot
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25],
                    instr[11:8], 1'b0};                                // halfword offset
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20],
                    instr[30:21], 1'b0};                               // halfword offset

endmodule : instr_fields

`default_nettype wire

//--- source/control_rom.sv
`default_nettype none

module control_rom (
    input  rv32i_pkg::rv32i_opcode       opcode,
    input  logic [2:0]                   funct3,
    input  logic [6:0]                   funct7,
    output rv32i_pkg::rv32i_control_word ctrl
);

    always_comb begin
        ctrl          = '0;                   // everything off by default
        ctrl.opcode   = opcode;
        ctrl.alu1_sel = rv32i_pkg::alu1_rs1;
        ctrl.alu2_sel = rv32i_pkg::alu2_rs2;

        case (opcode)
            rv32i_pkg::op_reg, rv32i_pkg::op_imm: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alu_op       = rv32i_pkg::alu_ops'(funct3);
                if (opcode == rv32i_pkg::op_imm) begin
                    ctrl.alu2_sel = rv32i_pkg::alu2_i_imm;
                end
                // funct7[5] picks the alternate op, sub only exists as reg-reg
                if (funct7[5] && funct3 == 3'b000 && opcode == rv32i_pkg::op_reg) begin
                    ctrl.alu_op = rv32i_pkg::alu_sub;
                end
                if (funct7[5] && funct3 == 3'b101) begin
                    ctrl.alu_op = rv32i_pkg::alu_sra;    // sra and srai
                end
            end

            rv32i_pkg::op_lui: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alu2_sel     = rv32i_pkg::alu2_u_imm;
            end

            rv32i_pkg::op_auipc: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alu1_sel     = rv32i_pkg::alu1_pc;  // pc + u_imm
                ctrl.alu2_sel     = rv32i_pkg::alu2_u_imm;
            end

            rv32i_pkg::op_load: begin
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.alu2_sel     = rv32i_pkg::alu2_i_imm;  // address = rs1 + i_imm
            end

            rv32i_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu2_sel  = rv32i_pkg::alu2_s_imm;
            end

            rv32i_pkg::op_br: begin
                ctrl.branch = 1'b1;
                ctrl.cmp_op = funct3;             // beq bne blt bge bltu bgeu
            end

            rv32i_pkg::op_jal: begin
                ctrl.jump         = 1'b1;
                ctrl.load_regfile = 1'b1;         // link to rd
            end

            rv32i_pkg::op_jalr: begin
                ctrl.jump         = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.alu2_sel     = rv32i_pkg::alu2_i_imm;  // target = rs1 + i_imm
            end

            default: begin
                ctrl         = '0;                // csr and unknown codes
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

//--- source/regfile.sv
`default_nettype none

`include "rv32i_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32i_pkg::wb_bundle  wb,            // from writeback, outside this stage
    input  logic [`RV_REGW-1:0]  src_a,
    input  logic [`RV_REGW-1:0]  src_b,
    output logic [`RV_XLEN-1:0]  reg_a,
    output logic [`RV_XLEN-1:0]  reg_b
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `RV_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wb.load && wb.rd != '0) begin    // x0 writes dropped
            regs[wb.rd] <= wb.data;
        end
    end

    // no bypass, a same-cycle read returns the old value
    assign reg_a = (src_a == '0) ? '0 : regs[src_a];
    assign reg_b = (src_b == '0) ? '0 : regs[src_b];

endmodule : regfile

`default_nettype wire

//--- source/decode.sv
`default_nettype none

`include "rv32i_settings.svh"

module decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,        // stall_n from the top
    input  rv32i_pkg::fetch_bundle if_id,
    input  rv32i_pkg::wb_bundle    wb,
    output rv32i_pkg::stage_regs   regs_out
);

    rv32i_pkg::rv32i_opcode       op;
    rv32i_pkg::rv32i_control_word ctrl;
    rv32i_pkg::stage_regs         stage;       // next value of id/ex
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [`RV_REGW-1:0]          src_a;
    logic [`RV_REGW-1:0]          src_b;
    logic [`RV_REGW-1:0]          rd_idx;
    logic [`RV_XLEN-1:0]          reg_a;
    logic [`RV_XLEN-1:0]          reg_b;

    instr_fields fields (
        .instr   (if_id.instr),
        .opcode  (op),
        .funct3  (funct3),
        .funct7  (funct7),
        .rs1_idx (src_a),
        .rs2_idx (src_b),
        .rd_idx  (rd_idx),
        .i_imm   (stage.i_imm),               // immediates go straight to ex
        .s_imm   (stage.s_imm),
        .b_imm   (stage.b_imm),
        .u_imm   (stage.u_imm),
        .j_imm   (stage.j_imm)
    );

    control_rom rom (
        .opcode (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    // writes keep landing during a stall, wb is not gated by load
    regfile rf (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb),
        .src_a (src_a),
        .src_b (src_b),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    assign stage.valid  = if_id.valid;
    assign stage.pc     = if_id.pc;
    assign stage.rs1    = reg_a;
    assign stage.rs2    = reg_b;
    assign stage.rd     = rd_idx;
    assign stage.funct3 = funct3;
    assign stage.ctrl   = ctrl;

    pipe_reg #(.payload_t(rv32i_pkg::stage_regs)) id_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .in    (stage),
        .out   (regs_out)
    );

endmodule : decode

`default_nettype wire

//--- source/id_stage_top.sv
`default_nettype none

// if/id register followed by decode and the id/ex register
module id_stage_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall_n,      // 0 freezes both registers
    input  rv32i_pkg::fetch_bundle fetch_in,
    input  rv32i_pkg::wb_bundle    wb_in,
    output rv32i_pkg::stage_regs   regs_out
);

    rv32i_pkg::fetch_bundle if_id_q;

    pipe_reg #(.payload_t(rv32i_pkg::fetch_bundle)) if_id_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (stall_n),
        .in    (fetch_in),
        .out   (if_id_q)                       // one cycle behind fetch_in
    );

    decode id (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (stall_n),                   // same level holds id/ex
        .if_id    (if_id_q),
        .wb       (wb_in),
        .regs_out (regs_out)                   // two cycles behind fetch_in
    );

endmodule : id_stage_top

`default_nettype wire

//--- test/id_stage_tb.sv
`default_nettype none

`include "rv32i_settings.svh"

module id_stage_tb;

    localparam int reset_cycles = 16;
    localparam int n_rand       = 16;
    localparam int n_items      = 150;                 // decoded items, upper bound

    logic                   clk;
    logic                   rst_n;
    logic                   stall_n;
    rv32i_pkg::fetch_bundle fetch_in;
    rv32i_pkg::wb_bundle    wb_in;
    rv32i_pkg::stage_regs   regs_out;
    logic [`RV_XLEN-1:0]    model_rf [`RV_NREGS];      // x0 entry never written
    logic [6:0]             classes [10] = '{rv32i_pkg::op_lui, rv32i_pkg::op_auipc,
        rv32i_pkg::op_jal, rv32i_pkg::op_jalr, rv32i_pkg::op_br, rv32i_pkg::op_load,
        rv32i_pkg::op_store, rv32i_pkg::op_imm, rv32i_pkg::op_reg, rv32i_pkg::op_csr};

    id_stage_top DUT (.clk(clk), .rst_n(rst_n), .stall_n(stall_n), .fetch_in(fetch_in),
                      .wb_in(wb_in), .regs_out(regs_out));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // no item needs more than a handful of cycles
    initial begin
        repeat (reset_cycles + n_items * 40) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", reset_cycles + n_items * 40);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] rand_instr(input logic [6:0] op);
        logic [31:0] w;
        w = $urandom;
        return {w[31:7], op};
    endfunction

    // add x1, rs1, rs2
    function automatic logic [31:0] reg_instr(input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, 5'd1, 7'b0110011};
    endfunction

    function automatic rv32i_pkg::rv32i_control_word expect_ctrl(input logic [31:0] instr);
        rv32i_pkg::rv32i_control_word c;
        logic                         alt;
        c        = '0;
        alt      = instr[30];                          // funct7 bit 5
        c.opcode = rv32i_pkg::rv32i_opcode'(instr[6:0]);
        case (instr[6:0])
            rv32i_pkg::op_reg, rv32i_pkg::op_imm: begin
                c.load_regfile = 1'b1;
                c.alu_op       = rv32i_pkg::alu_ops'(instr[14:12]);
                if (alt && instr[14:12] == 3'b101) c.alu_op = rv32i_pkg::alu_sra;
                if (alt && instr[14:12] == 3'b000 && instr[5]) c.alu_op = rv32i_pkg::alu_sub;
                c.alu2_sel = instr[5] ? rv32i_pkg::alu2_rs2 : rv32i_pkg::alu2_i_imm;
            end
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc: begin
                c.load_regfile = 1'b1;
                c.alu2_sel     = rv32i_pkg::alu2_u_imm;
                c.alu1_sel     = instr[5] ? rv32i_pkg::alu1_rs1 : rv32i_pkg::alu1_pc;  // auipc
            end
            rv32i_pkg::op_load: begin
                c.mem_read     = 1'b1;
                c.load_regfile = 1'b1;
                c.alu2_sel     = rv32i_pkg::alu2_i_imm;
            end
            rv32i_pkg::op_store: begin
                c.mem_write = 1'b1;
                c.alu2_sel  = rv32i_pkg::alu2_s_imm;
            end
            rv32i_pkg::op_br: begin
                c.branch = 1'b1;
                c.cmp_op = instr[14:12];
            end
            rv32i_pkg::op_jal, rv32i_pkg::op_jalr: begin
                c.jump         = 1'b1;
                c.load_regfile = 1'b1;
                c.alu2_sel     = instr[3] ? rv32i_pkg::alu2_rs2 : rv32i_pkg::alu2_i_imm;  // jalr
            end
            default: begin
                c         = '0;                        // csr and unknown opcodes
                c.illegal = 1'b1;
            end
        endcase
        return c;
    endfunction

    function automatic rv32i_pkg::stage_regs expect_stage(input logic [31:0] instr,
                                                          input logic [31:0] pc);
        rv32i_pkg::stage_regs s;
        logic [31:0]          i_sx;
        i_sx     = {{20{instr[31]}}, instr[31:20]};
        s.valid  = 1'b1;
        s.pc     = pc;
        s.rs1    = model_rf[instr[19:15]];
        s.rs2    = model_rf[instr[24:20]];
        s.rd     = instr[11:7];
        s.funct3 = instr[14:12];
        s.i_imm  = i_sx;
        s.s_imm  = {i_sx[31:5], instr[11:7]};          // low five bits from rd slot
        s.b_imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        s.u_imm  = {instr[31:12], 12'h000};
        s.j_imm  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        s.ctrl   = expect_ctrl(instr);
        return s;
    endfunction

    task automatic check_stage(input string name, input rv32i_pkg::stage_regs exp,
                               input rv32i_pkg::stage_regs act);
        if (act !== exp) begin
            $display("mismatch t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "stage register check failed");
        end
    endtask

    task automatic check_ctrl(input string name, input rv32i_pkg::rv32i_control_word exp,
                              input rv32i_pkg::rv32i_control_word act);
        if (act !== exp) begin
            $display("mismatch t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "control word check failed");
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "data word check failed");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                            // drive just after the edge
    endtask

    // one item through if/id and id/ex, regs_out holds it on return
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc);
        fetch_in.valid = 1'b1;
        fetch_in.pc    = pc;
        fetch_in.instr = instr;
        step();
        fetch_in.valid = 1'b0;                         // bubble behind it
        step();
    endtask

    task automatic test_immediates();
        logic [31:0] instr;
        logic [31:0] pc;
        for (int i = 0; i < n_rand; i++) begin
            instr = rand_instr(classes[i % 10]);
            pc    = $urandom & 32'hffff_fffc;
            issue(instr, pc);
            check_stage("regs_out", expect_stage(instr, pc), regs_out);
        end
    endtask

    task automatic test_control();
        logic [31:0] instr;
        for (int i = 0; i < 10; i++) begin
            instr = rand_instr(classes[i]);
            issue(instr, 32'h100 + 4 * i);
            check_ctrl("regs_out.ctrl", expect_ctrl(instr), regs_out.ctrl);
        end
        for (int k = 0; k < 32; k++) begin
            instr        = rand_instr(k[4] ? rv32i_pkg::op_imm : rv32i_pkg::op_reg);
            instr[14:12] = k[2:0];
            instr[31:25] = k[3] ? 7'b0100000 : 7'b0000000;   // alternate op bit
            issue(instr, 32'h180 + 4 * k);
            check_ctrl("regs_out.ctrl", expect_ctrl(instr), regs_out.ctrl);
        end
    endtask

    task automatic test_regfile();
        logic [4:0]  rd;
        logic [31:0] old;
        for (int i = 0; i < 2 * `RV_NREGS; i++) begin
            rd         = (i == 0) ? 5'd0 : 5'($urandom);   // first write aims at x0
            wb_in.load = 1'b1;
            wb_in.rd   = rd;
            wb_in.data = $urandom;
            if (rd != 5'd0) model_rf[rd] = wb_in.data;
            step();
        end
        wb_in.load = 1'b0;
        for (int i = 0; i < `RV_NREGS / 2; i++) begin
            issue(reg_instr(5'(i), 5'(31 - i)), 32'h200 + 4 * i);
            check_word("regs_out.rs1", model_rf[i], regs_out.rs1);
            check_word("regs_out.rs2", model_rf[31 - i], regs_out.rs2);
        end
        // write lands on the same edge that captures the read
        old            = model_rf[9];
        fetch_in.valid = 1'b1;
        fetch_in.instr = reg_instr(5'd9, 5'd9);
        step();
        fetch_in.valid = 1'b0;
        wb_in.load     = 1'b1;
        wb_in.rd       = 5'd9;
        wb_in.data     = ~old;
        step();
        wb_in.load     = 1'b0;
        model_rf[9]    = ~old;
        check_word("regs_out.rs1", old, regs_out.rs1);
        issue(reg_instr(5'd9, 5'd9), 32'h300);
        check_word("regs_out.rs2", ~old, regs_out.rs2);
    endtask

    task automatic test_stall();
        logic [31:0] first;
        logic [31:0] second;
        first          = rand_instr(rv32i_pkg::op_reg);
        second         = rand_instr(rv32i_pkg::op_load);
        fetch_in.valid = 1'b1;
        fetch_in.pc    = 32'h600;
        fetch_in.instr = first;
        step();
        fetch_in.pc    = 32'h604;
        fetch_in.instr = second;
        step();
        stall_n        = 1'b0;
        fetch_in.pc    = 32'h608;                      // third item, must stay out
        fetch_in.instr = rand_instr(rv32i_pkg::op_store);
        repeat (5) begin
            step();
            check_stage("regs_out", expect_stage(first, 32'h600), regs_out);
        end
        stall_n        = 1'b1;
        fetch_in.valid = 1'b0;
        step();
        check_stage("regs_out", expect_stage(second, 32'h604), regs_out);
    endtask

    task automatic test_reset();
        rv32i_pkg::stage_regs drained;
        drained        = expect_stage(32'h0, 32'h0);
        drained.valid  = 1'b0;                         // cleared if/id decodes as a bubble
        fetch_in.valid = 1'b1;
        fetch_in.instr = reg_instr(5'd3, 5'd4);
        step();
        rst_n = 1'b0;                                  // item still in if/id
        step();
        step();
        rst_n          = 1'b1;
        fetch_in.valid = 1'b0;
        check_stage("regs_out", '0, regs_out);
        step();
        check_stage("regs_out", drained, regs_out);    // held item must not surface
        for (int r = 0; r < `RV_NREGS; r++) model_rf[r] = '0;
        for (int i = 0; i < `RV_NREGS / 2; i++) begin
            issue(reg_instr(5'(i), 5'(i + 16)), 32'h400 + 4 * i);
            check_word("regs_out.rs1", 32'h0, regs_out.rs1);
            check_word("regs_out.rs2", 32'h0, regs_out.rs2);
        end
    endtask

    task automatic test_illegal();
        rv32i_pkg::rv32i_control_word exp;
        logic [31:0]                  instr;
        logic                         known;
        int                           found;
        exp         = '0;
        exp.illegal = 1'b1;
        found       = 0;
        while (found < 8) begin
            instr = $urandom;
            known = 1'b0;
            foreach (classes[c]) known |= (classes[c] == instr[6:0]);
            if (!known) begin
                issue(instr, 32'h500 + 4 * found);
                check_ctrl("regs_out.ctrl", exp, regs_out.ctrl);
                found++;
            end
        end
    endtask

    initial begin
        void'($urandom(20146));
        rst_n    = 1'b0;
        stall_n  = 1'b1;
        fetch_in = '0;
        wb_in    = '0;
        for (int r = 0; r < `RV_NREGS; r++) model_rf[r] = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_immediates();
        test_control();
        test_regfile();
        test_stall();
        test_reset();
        test_illegal();
        $display(">>> PASS");
        $finish;
    end

endmodule : id_stage_tb

`default_nettype wire

//--- filelist.f
+incdir+source
source/rv32i_pkg.sv
source/pipe_reg.sv
source/instr_fields.sv
source/control_rom.sv
source/regfile.sv
source/decode.sv
source/id_stage_top.sv
test/id_stage_tb.sv
